//--- source/reprog_pkg.sv
package reprog_pkg;

	// ==================================================
	// widths fixed by the configuration port protocol
	// ==================================================

	localparam int ICAP_WORD_W  = 32;	// port data bus
	localparam int FLASH_ADDR_W = 24;	// bitstream start address
	localparam int TRIGGER_W    = 3;	// one request bit per image
	localparam int IMAGE_W      = 2;
	localparam int SLOT_W       = 3;	// eight command words

	typedef logic [ICAP_WORD_W-1:0]  icap_word_t;
	typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
	typedef logic [TRIGGER_W-1:0]    trigger_t;
	typedef logic [IMAGE_W-1:0]      image_t;
	typedef logic [SLOT_W-1:0]       slot_t;

	// image index, same as the trigger bit position
	localparam image_t IMG_GOLDEN = 2'd0;
	localparam image_t IMG_MASTER = 2'd1;
	localparam image_t IMG_STMSTR = 2'd2;	// self-triggering master

	// ==================================================
	// command words, before byte bit reversal
	// ==================================================

	localparam icap_word_t ICAP_DUMMY_WORD   = 32'hFFFF_FFFF;
	localparam icap_word_t ICAP_SYNC_WORD    = 32'hAA99_5566;
	localparam icap_word_t ICAP_NO_OP        = 32'h2000_0000;	// type 1 noop
	localparam icap_word_t ICAP_WRITE_WBSTAR = 32'h3002_0001;	// write 1 word to WBSTAR
	localparam icap_word_t ICAP_WRITE_CMD    = 32'h3000_8001;	// write 1 word to CMD
	localparam icap_word_t ICAP_IPROG        = 32'h0000_000F;

	// flash start addresses of the three images
	localparam flash_addr_t GOLDEN_FLASH_ADDR = 24'h00_0000;
	localparam flash_addr_t MASTER_FLASH_ADDR = 24'h40_0000;
	localparam flash_addr_t STMSTR_FLASH_ADDR = 24'h80_0000;

	// index of the final command word
	localparam slot_t SEQ_LAST = 3'd7;

	// sequencer states
	typedef enum logic [1:0] {
		ST_IDLE,	// waiting for a trigger bit
		ST_SEND,	// eight words on the port
		ST_DONE 	// parked until reset
	} reprog_state_t;

endpackage

//--- source/image_select.sv
module image_select (
	input  logic                clk,
	input  logic                reset,
	input  logic                start,	// one cycle, sequence begins
	input  reprog_pkg::trigger_t trigger,
	output reprog_pkg::image_t   image
);

	// ==================================================
	// priority pick, lowest set bit wins
	// ==================================================

	reprog_pkg::image_t image_next;

	always_comb begin
		if (trigger[reprog_pkg::IMG_GOLDEN]) begin
			image_next = reprog_pkg::IMG_GOLDEN;
		end else if (trigger[reprog_pkg::IMG_MASTER]) begin
			image_next = reprog_pkg::IMG_MASTER;
		end else if (trigger[reprog_pkg::IMG_STMSTR]) begin
			image_next = reprog_pkg::IMG_STMSTR;
		end else begin
			image_next = reprog_pkg::IMG_GOLDEN;	// no bit set, start never fires here
		end
	end

	// ==================================================
	// latch at start and hold for the whole sequence
	// ==================================================

	// trigger may move mid-sequence, address word must not
	always_ff @(posedge clk) begin
		if (reset) begin
			image <= reprog_pkg::IMG_GOLDEN;
		end else if (start) begin
			image <= image_next;
		end
	end

endmodule

//--- source/word_counter.sv
module word_counter (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,	// reload slot 0
	input  logic             send,	// advance one slot per edge
	output reprog_pkg::slot_t slot,
	output logic             last
);

	// slot counter, wraps to 0 after the final word
	always_ff @(posedge clk) begin
		if (reset) begin
			slot <= '0;
		end else if (start) begin
			slot <= '0;
		end else if (send) begin
			slot <= slot + 1'b1;
		end
	end

	// final word is on its way out this cycle
	assign last = send && (slot == reprog_pkg::SEQ_LAST);

endmodule

//--- source/reprog_fsm.sv
module reprog_fsm (
	input  logic                clk,
	input  logic                reset,
	input  reprog_pkg::trigger_t trigger,
	input  logic                last,	// final slot from the counter
	output logic                start,
	output logic                send,
	output logic                reprog_done
);

	reprog_pkg::reprog_state_t state;
	reprog_pkg::reprog_state_t state_next;

	// ==================================================
	// next state
	// ==================================================

	always_comb begin
		state_next = state;
		case (state)
			reprog_pkg::ST_IDLE: begin
				if (trigger != '0) begin
					state_next = reprog_pkg::ST_SEND;
				end
			end
			reprog_pkg::ST_SEND: begin
				if (last) begin
					state_next = reprog_pkg::ST_DONE;
				end
			end
			reprog_pkg::ST_DONE: begin
				state_next = reprog_pkg::ST_DONE;	// FPGA reconfigures from here, only reset leaves
			end
			default: begin
				state_next = reprog_pkg::ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= reprog_pkg::ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// ==================================================
	// outputs, decoded from state
	// ==================================================

	// start is high the cycle before the idle to send edge
	assign start       = (state == reprog_pkg::ST_IDLE) && (trigger != '0);
	assign send        = (state == reprog_pkg::ST_SEND);	// exactly eight cycles
	assign reprog_done = (state == reprog_pkg::ST_DONE);

endmodule

//--- source/icap_word_rom.sv
module icap_word_rom (
	input  reprog_pkg::slot_t      slot,
	input  reprog_pkg::image_t     image,
	output reprog_pkg::icap_word_t word
);

	reprog_pkg::flash_addr_t flash_addr;

	// ==================================================
	// flash start address of the latched image
	// ==================================================

	always_comb begin
		case (image)
			reprog_pkg::IMG_GOLDEN: flash_addr = reprog_pkg::GOLDEN_FLASH_ADDR;
			reprog_pkg::IMG_MASTER: flash_addr = reprog_pkg::MASTER_FLASH_ADDR;
			reprog_pkg::IMG_STMSTR: flash_addr = reprog_pkg::STMSTR_FLASH_ADDR;
			default:                flash_addr = reprog_pkg::GOLDEN_FLASH_ADDR;	// unused index
		endcase
	end

	// ==================================================
	// IPROG command sequence, one word per slot
	// ==================================================

	always_comb begin
		case (slot)
			3'd0: word = reprog_pkg::ICAP_DUMMY_WORD;
			3'd1: word = reprog_pkg::ICAP_SYNC_WORD;
			3'd2: word = reprog_pkg::ICAP_NO_OP;
			3'd3: word = reprog_pkg::ICAP_WRITE_WBSTAR;
			3'd4: begin
				// WBSTAR payload, zero-extended flash address
				word = {{(reprog_pkg::ICAP_WORD_W - reprog_pkg::FLASH_ADDR_W){1'b0}},
					flash_addr};
			end
			3'd5: word = reprog_pkg::ICAP_WRITE_CMD;
			3'd6: word = reprog_pkg::ICAP_IPROG;
			3'd7: word = reprog_pkg::ICAP_NO_OP;	// flush
			default: word = reprog_pkg::ICAP_NO_OP;
		endcase
	end

endmodule

//--- source/icap_output.sv
module icap_output (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  send,
	input  reprog_pkg::icap_word_t word,
	output reprog_pkg::icap_word_t icap_data,
	output logic                  icap_csib	// active low port enable
);

	// ==================================================
	// port wants each byte with its bits swapped
	// ==================================================

	function automatic reprog_pkg::icap_word_t byte_swap_bits(input reprog_pkg::icap_word_t w);
		reprog_pkg::icap_word_t r;
		for (int b = 0; b < reprog_pkg::ICAP_WORD_W / 8; b++) begin
			for (int i = 0; i < 8; i++) begin
				r[8*b + i] = w[8*b + 7 - i];	// msb of a byte lands on its lsb
			end
		end
		return r;
	endfunction

	// ==================================================
	// registered port drive
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			icap_data <= byte_swap_bits(reprog_pkg::ICAP_DUMMY_WORD);
			icap_csib <= 1'b1;	// disabled
		end else if (send) begin
			icap_data <= byte_swap_bits(word);
			icap_csib <= 1'b0;	// enabled, one word per edge
		end else begin
			if (!icap_csib) begin
				icap_data <= byte_swap_bits(reprog_pkg::ICAP_NO_OP);	// sequence just ended
			end
			icap_csib <= 1'b1;
		end
	end

endmodule

//--- source/reprog_top.sv
module reprog_top (
	input  logic                  clk,
	input  logic                  reset,
	input  reprog_pkg::trigger_t   trigger,	// bit 0 golden, 1 master, 2 self-triggering master
	output reprog_pkg::icap_word_t icap_data,
	output logic                  icap_csib,
	output logic                  reprog_done
);

	// ==================================================
	// internal nets
	// ==================================================

	logic                  start;	// one cycle, from idle with a trigger
	logic                  send;	// high for the eight word cycles
	logic                  last;
	reprog_pkg::slot_t      slot;
	reprog_pkg::image_t     image;
	reprog_pkg::icap_word_t word;	// unreversed, combinational

	reprog_fsm reprog_fsm_inst (
		.clk         (clk),
		.reset       (reset),
		.trigger     (trigger),
		.last        (last),
		.start       (start),
		.send        (send),
		.reprog_done (reprog_done)
	);

	word_counter word_counter_inst (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.send  (send),
		.slot  (slot),
		.last  (last)
	);

	image_select image_select_inst (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.trigger (trigger),
		.image   (image)
	);

	icap_word_rom icap_word_rom_inst (
		.slot  (slot),
		.image (image),
		.word  (word)
	);

	// drives the configuration port pins
	icap_output icap_output_inst (
		.clk       (clk),
		.reset     (reset),
		.send      (send),
		.word      (word),
		.icap_data (icap_data),
		.icap_csib (icap_csib)
	);

endmodule

//--- verification/icap_capture.sv
module icap_capture (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   icap_csib,	// active low enable from the DUT
	input  reprog_pkg::icap_word_t icap_data,
	output int                     count,	// words seen since reset
	output reprog_pkg::icap_word_t words [0:15]
);
	timeunit 1ns;
	timeprecision 1ps;

	// port takes one word per rising edge while enabled
	always @(posedge clk) begin
		if (reset) begin
			count <= 0;
		end else if (!icap_csib) begin
			if (count < 16) begin
				words[count[3:0]] <= icap_data;
			end
			count <= count + 1;	// keeps counting past the array, extra words still show
		end
	end

endmodule

//--- verification/reprog_tb.sv
module reprog_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                   clk;
	logic                   reset;
	reprog_pkg::trigger_t   trigger;
	reprog_pkg::icap_word_t icap_data;
	logic                   icap_csib;
	logic                   reprog_done;
	int                     cap_count;
	reprog_pkg::icap_word_t cap_words [0:15];

	always #10 clk = ~clk;	// 20 ns

	reprog_top reprog_top_inst (
		.clk         (clk),
		.reset       (reset),
		.trigger     (trigger),
		.icap_data   (icap_data),
		.icap_csib   (icap_csib),
		.reprog_done (reprog_done)
	);

	icap_capture icap_capture_inst (
		.clk       (clk),
		.reset     (reset),
		.icap_csib (icap_csib),
		.icap_data (icap_data),
		.count     (cap_count),
		.words     (cap_words)
	);

	// ==================================================
	// expected values
	// ==================================================

	// bit i of a byte comes from bit 7-i of the same byte
	function automatic reprog_pkg::icap_word_t reverse_byte_bits(
		input reprog_pkg::icap_word_t w);
		reprog_pkg::icap_word_t r;
		for (int i = 0; i < 32; i++) begin
			r[i] = w[(i / 8) * 8 + 7 - (i % 8)];
		end
		return r;
	endfunction

	function automatic reprog_pkg::flash_addr_t expected_addr(input reprog_pkg::trigger_t t);
		if (t[0]) return reprog_pkg::GOLDEN_FLASH_ADDR;	// lowest set bit wins
		if (t[1]) return reprog_pkg::MASTER_FLASH_ADDR;
		return reprog_pkg::STMSTR_FLASH_ADDR;
	endfunction

	function automatic reprog_pkg::icap_word_t expected_word(input int n,
		input reprog_pkg::flash_addr_t addr);
		case (n)
			0: return reprog_pkg::ICAP_DUMMY_WORD;
			1: return reprog_pkg::ICAP_SYNC_WORD;
			3: return reprog_pkg::ICAP_WRITE_WBSTAR;
			4: return {8'h00, addr};	// WBSTAR payload
			5: return reprog_pkg::ICAP_WRITE_CMD;
			6: return reprog_pkg::ICAP_IPROG;
			default: return reprog_pkg::ICAP_NO_OP;	// words 2 and 7
		endcase
	endfunction

	// ==================================================
	// compare tasks
	// ==================================================

	task automatic stop_on_failure(input string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input reprog_pkg::icap_word_t exp,
		input reprog_pkg::icap_word_t act);
		if (act !== exp) begin
			stop_on_failure($sformatf("ERROR %s expected %h got %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_on_failure($sformatf("ERROR %s expected %h got %h", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			stop_on_failure($sformatf("ERROR %s expected %0h got %0h", name, exp, act));
		end
	endtask

	// ==================================================
	// stimulus driven on the falling edge
	// ==================================================

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		trigger = '0;
		repeat (3) @(negedge clk);	// three rising edges in reset
		reset = 1'b0;
	endtask

	task automatic check_idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			check_bit("icap_csib", 1'b1, icap_csib);
			check_bit("reprog_done", 1'b0, reprog_done);
			check_word("icap_data", reverse_byte_bits(reprog_pkg::ICAP_DUMMY_WORD), icap_data);
		end
	endtask

	// one full sequence from a fresh reset
	// n counts falling edges after the trigger
	task automatic run_sequence(input reprog_pkg::trigger_t trig, input logic disturb);
		int n;
		int lows;
		int first_low;
		int last_low;
		int done_at;
		int change_at;
		reprog_pkg::flash_addr_t addr;
		apply_reset();
		check_idle($urandom_range(2, 12));
		addr = expected_addr(trig);
		change_at = $urandom_range(2, 8);	// somewhere mid-sequence
		n = 0;
		lows = 0;
		first_low = 0;
		last_low = 0;
		done_at = 0;
		trigger = trig;	// next rising edge is the trigger edge
		do begin
			@(negedge clk);
			n++;
			if (n > 50) stop_on_failure("timeout, the sequence did not finish");
			if (!icap_csib) begin
				if (lows == 0) first_low = n;
				last_low = n;
				lows++;
			end
			if (reprog_done && done_at == 0) done_at = n;
			if (done_at != 0) check_bit("reprog_done", 1'b1, reprog_done);	// must stay high
			if (n == 1) trigger = '0;	// latched already
			if (disturb && n == change_at) trigger = reprog_pkg::trigger_t'($urandom_range(1, 7));
		end while (!(reprog_done && icap_csib));
		check_count("edges from trigger to reprog_done", 8, done_at - 1);
		check_count("edges from trigger to first word", 1, first_low - 1);
		check_count("icap_csib low cycles", 8, lows);
		check_count("icap_csib low span", 8, last_low - first_low + 1);	// one unbroken run
		check_count("captured words", 8, cap_count);
		for (int s = 0; s < 8; s++) begin
			check_word($sformatf("icap_data word %0d", s + 1),
				reverse_byte_bits(expected_word(s, addr)), cap_words[s]);
		end
		check_word("icap_data after sequence",
			reverse_byte_bits(reprog_pkg::ICAP_NO_OP), icap_data);
	endtask

	// ==================================================
	// directed tests
	// ==================================================

	task automatic idle_test();
		apply_reset();
		check_idle($urandom_range(5, 30));
		check_count("captured words", 0, cap_count);
	endtask

	task automatic multi_bit_test();
		reprog_pkg::trigger_t t;
		run_sequence(3'b110, 1'b1);
		repeat (4) begin
			case ($urandom_range(0, 3))
				0: t = 3'b011;
				1: t = 3'b101;
				2: t = 3'b110;
				default: t = 3'b111;
			endcase
			run_sequence(t, 1'b1);
		end
	endtask

	task automatic done_state_test();
		run_sequence(3'b001, 1'b0);
		trigger = reprog_pkg::trigger_t'($urandom_range(1, 7));	// ignored once done
		repeat (20) begin
			@(negedge clk);
			check_bit("icap_csib", 1'b1, icap_csib);
			check_bit("reprog_done", 1'b1, reprog_done);
		end
		check_count("captured words", 8, cap_count);
		apply_reset();
		check_bit("reprog_done", 1'b0, reprog_done);
		check_count("captured words", 0, cap_count);
		run_sequence(3'b100, 1'b0);	// a new sequence runs after reset
	endtask

	initial begin
		void'($urandom(78839));
		clk = 1'b0;
		reset = 1'b1;
		trigger = '0;
		idle_test();
		run_sequence(3'b001, 1'b0);	// golden
		run_sequence(3'b010, 1'b0);	// master
		run_sequence(3'b100, 1'b0);	// self-triggering master
		multi_bit_test();
		done_state_test();
		$display("sim passed");
		$finish;
	end

endmodule

//--- filelist.f
source/reprog_pkg.sv
source/image_select.sv
source/word_counter.sv
source/reprog_fsm.sv
source/icap_word_rom.sv
source/icap_output.sv
source/reprog_top.sv
verification/icap_capture.sv
verification/reprog_tb.sv

//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module reprog_tb -f filelist.f -o Vreprog_tb

run: build
	@out="$$(./obj_dir/Vreprog_tb)"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	verilator --lint-only -Wall --timing --top-module reprog_tb -f filelist.f

clean:
	rm -rf obj_dir
